//--- compile.f
+incdir+common
common/uart_cmd_pkg.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
hdl/uart_cmd_ctrl.sv
hdl/uart_cmd_bridge.sv
verification/uart_dev_model.sv
verification/tb_uart_cmd.sv

//--- verification/tb_uart_cmd.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module tb_uart_cmd import uart_cmd_pkg::*; ();

  localparam int NUM_TESTS = 12;
  localparam int WATCHDOG_CYCLES = 2 * (NUM_TESTS * 3 * `UART_FRAME_BITS * `UART_CLKS_PER_BIT
                                        + NUM_TESTS * `UART_RESP_TIMEOUT);

  // {rw, addr} per command, first entry in the top byte
  localparam logic [NUM_TESTS*8-1:0] CMD_LIST = {
    8'h05, 8'h85, 8'h12, 8'h33, 8'h92, 8'hb3,
    8'h7f, 8'hff, 8'hfe, 8'h40, 8'hc0, 8'h86
  };

  typedef struct packed {
    logic       rw;
    reg_addr_t  addr;
    uart_byte_t data;
    uart_byte_t exp_data;
    logic       exp_bad;
    logic       exp_timeout;
  } test_t;

  logic        clk;
  logic        rst_n;
  cmd_t        cmd;
  logic        cmd_valid;
  logic        cmd_ready;
  logic        rd_valid;
  rd_resp_t    rd_resp;
  logic        ser_to_dut;
  logic        ser_from_dut;
  test_t       tests [NUM_TESTS];
  uart_byte_t  shadow [128];
  logic [15:0] lfsr;
  int          err_count;
  int          pass_count;
  int          fail_count;
  int          rd_count;
  int          num_reads;

  always #4 clk = ~clk;

  uart_cmd_bridge uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rd_valid  (rd_valid),
    .rd_resp   (rd_resp),
    .rx        (ser_to_dut),
    .tx        (ser_from_dut)
  );

  uart_dev_model dev (
    .clk     (clk),
    .ser_in  (ser_from_dut),
    .ser_out (ser_to_dut)
  );

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic lfsr_byte(output uart_byte_t b);
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr[15];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      err_count++;
    end
  endtask

  task automatic report_test(input string label, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("%s: ok", label);
    end else begin
      fail_count++;
      $display("%s: FAILED", label);
    end
  endtask

  // shadow memory follows the device rules to give expected read values
  task automatic build_table();
    logic [7:0] ra;
    uart_byte_t wd;
    num_reads = 0;
    for (int a = 0; a < 128; a++) begin
      shadow[a] = '0;
    end
    for (int i = 0; i < NUM_TESTS; i++) begin
      ra = CMD_LIST[(NUM_TESTS - 1 - i) * 8 +: 8];
      tests[i] = '0;
      tests[i].rw = ra[7];
      tests[i].addr = ra[6:0];
      if (!ra[7]) begin
        lfsr_byte(wd);
        tests[i].data = wd;
        shadow[ra[6:0]] = wd;
      end else begin
        num_reads++;
        if (ra[6:0] == 7'h7e) begin
          tests[i].exp_timeout = 1'b1;
        end else begin
          tests[i].exp_data = shadow[ra[6:0]];
          tests[i].exp_bad = (ra[6:0] == 7'h7f);
        end
      end
    end
  endtask

  task automatic wait_cmd_ready();
    @(posedge clk);
    while (!cmd_ready) begin
      @(posedge clk);
    end
  endtask

  // called on the edge where cmd_ready is back, rd_valid coincides for reads
  task automatic finish_test(input int i);
    int errs_before;
    errs_before = err_count;
    if (tests[i].rw) begin
      check_value("rd_valid", rd_valid, 1'b1);
      check_value("rd_resp.data", rd_resp.data, tests[i].exp_data);
      check_value("rd_resp.bad_frame", rd_resp.bad_frame, tests[i].exp_bad);
      check_value("rd_resp.timeout", rd_resp.timeout, tests[i].exp_timeout);
    end else begin
      check_value("rd_valid", rd_valid, 1'b0);
    end
    report_test($sformatf("test %0d %s addr %h data %h", i, tests[i].rw ? "read" : "write",
                          tests[i].addr, tests[i].rw ? rd_resp.data : tests[i].data),
                errs_before);
  endtask

  always @(posedge clk) begin
    if (rst_n && rd_valid) begin
      rd_count++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, a command never completed", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin
    int errs_before;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd = '0;
    cmd_valid = 1'b0;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    rd_count = 0;
    lfsr = 16'd2779;
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    errs_before = err_count;
    check_value("tx", ser_from_dut, 1'b1);
    check_value("cmd_ready", cmd_ready, 1'b1);
    check_value("rd_valid", rd_valid, 1'b0);
    report_test("reset values", errs_before);

    // cmd_valid stays high from the first command to the last
    cmd <= '{rw: tests[0].rw, addr: tests[0].addr, data: tests[0].data};
    cmd_valid <= 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      wait_cmd_ready();
      if (i > 0) begin
        finish_test(i - 1);
      end
      if (i + 1 < NUM_TESTS) begin
        cmd <= '{rw: tests[i+1].rw, addr: tests[i+1].addr, data: tests[i+1].data};
      end else begin
        cmd_valid <= 1'b0;
      end
    end
    wait_cmd_ready();
    finish_test(NUM_TESTS - 1);

    repeat (4) @(posedge clk);
    errs_before = err_count;
    check_value("frame_count", dev.frame_count, 2 * NUM_TESTS);
    check_value("bad_par_count", dev.bad_par_count, 0);
    check_value("rd_count", rd_count, num_reads);
    report_test("frame counts", errs_before);

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- verification/uart_dev_model.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module uart_dev_model import uart_cmd_pkg::*; (
  input  logic clk,
  input  logic ser_in,
  output logic ser_out
);

  localparam int CPB = `UART_CLKS_PER_BIT;

  uart_byte_t mem [128];
  int         frame_count;
  int         bad_par_count;

  // returns at the middle of the stop bit
  task automatic recv_frame(output uart_byte_t b);
    logic par;
    @(posedge clk);
    while (ser_in !== 1'b0) begin
      @(posedge clk);
    end
    repeat (CPB / 2) @(posedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(posedge clk);
      b[i] = ser_in;
    end
    repeat (CPB) @(posedge clk);
    par = ser_in;
    repeat (CPB) @(posedge clk);
    frame_count++;
    if ((^{b, par}) !== 1'b1) begin
      bad_par_count++;
    end
  endtask

  // start, data lsb first, odd parity (optionally flipped), stop
  task automatic send_frame(input uart_byte_t b, input logic flip_par);
    logic [10:0] bits;
    bits = {1'b1, (~^b) ^ flip_par, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ser_out <= bits[i];
      repeat (CPB) @(posedge clk);
    end
  endtask

  initial begin
    uart_byte_t hi;
    uart_byte_t lo;
    ser_out = 1'b1;
    frame_count = 0;
    bad_par_count = 0;
    for (int a = 0; a < 128; a++) begin
      mem[a] = '0;
    end
    forever begin
      recv_frame(hi);
      recv_frame(lo);
      if (!hi[7]) begin
        mem[hi[6:0]] = lo;
      end else if (hi[6:0] != 7'h7e) begin
        // reply starts about two bit times after the stop bit
        repeat (CPB / 2 + 2 * CPB) @(posedge clk);
        send_frame(mem[hi[6:0]], hi[6:0] == 7'h7f);
      end
    end
  end

endmodule

//--- hdl/uart_cmd_bridge.sv
`timescale 1ns/1ps

module uart_cmd_bridge import uart_cmd_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  output logic     rd_valid,
  output rd_resp_t rd_resp,
  input  logic     rx,
  output logic     tx
);

  uart_byte_t tx_byte;
  logic       tx_valid;
  logic       tx_ready;
  uart_byte_t rx_byte;
  logic       rx_valid;
  logic       rx_bad;
  logic       rx_busy;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .rx_bad    (rx_bad),
    .rx_busy   (rx_busy),
    .rd_valid  (rd_valid),
    .rd_resp   (rd_resp)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_rx u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_bad   (rx_bad),
    .rx_busy  (rx_busy)
  );

endmodule

//--- hdl/uart_cmd_ctrl.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module uart_cmd_ctrl import uart_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  output uart_byte_t tx_byte,
  output logic       tx_valid,
  input  logic       tx_ready,
  input  uart_byte_t rx_byte,
  input  logic       rx_valid,
  input  logic       rx_bad,
  input  logic       rx_busy,
  output logic       rd_valid,
  output rd_resp_t   rd_resp
);

  localparam int TO_W = $clog2(`UART_RESP_TIMEOUT + 1);
  localparam logic [TO_W-1:0] TO_LAST = TO_W'(`UART_RESP_TIMEOUT - 1);

  ctrl_state_e     state;
  cmd_t            cmd_q;
  logic            lo_sent;
  logic [TO_W-1:0] to_cnt;
  logic            take_cmd;
  logic            lo_done;
  logic            got_resp;
  logic            timed_out;

  assign cmd_ready = (state == IDLE);
  assign take_cmd  = cmd_valid & cmd_ready;

  assign tx_valid = (state == SEND_HI) | ((state == SEND_LO) & ~lo_sent);
  assign tx_byte  = (state == SEND_HI) ? {cmd_q.rw, cmd_q.addr} : cmd_q.data;

  // second frame has left once the serializer is free again
  assign lo_done = (state == SEND_LO) & lo_sent & tx_ready;

  // a reply frame wins over a timeout in the same cycle
  assign got_resp  = (state == WAIT_RESP) & rx_valid;
  assign timed_out = (state == WAIT_RESP) & ~rx_valid & ~rx_busy & (to_cnt == TO_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      lo_sent  <= 1'b0;
      to_cnt   <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= got_resp | timed_out;
      case (state)
        IDLE: begin
          lo_sent <= 1'b0;
          if (take_cmd) begin
            state <= SEND_HI;
          end
        end
        SEND_HI: begin
          if (tx_ready) begin
            state <= SEND_LO;
          end
        end
        SEND_LO: begin
          if (!lo_sent && tx_ready) begin
            lo_sent <= 1'b1;
          end else if (lo_done) begin
            lo_sent <= 1'b0;
            to_cnt  <= '0;
            state   <= cmd_q.rw ? WAIT_RESP : IDLE;
          end
        end
        WAIT_RESP: begin
          if (got_resp || timed_out) begin
            state <= IDLE;
          end else if (!rx_busy) begin
            // paused while a reply frame is coming in
            to_cnt <= to_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_cmd) begin
      cmd_q <= cmd;
    end
    if (got_resp) begin
      rd_resp <= '{data: rx_byte, bad_frame: rx_bad, timeout: 1'b0};
    end else if (timed_out) begin
      rd_resp <= '{data: '0, bad_frame: 1'b0, timeout: 1'b1};
    end
  end

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module uart_rx import uart_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output uart_byte_t rx_byte,
  output logic       rx_valid,
  output logic       rx_bad,
  output logic       rx_busy
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam int IDX_W = $clog2(`UART_FRAME_BITS);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] DATA_LAST = IDX_W'(`UART_DATA_BITS);
  localparam logic [IDX_W-1:0] PAR_IDX   = IDX_W'(`UART_DATA_BITS + 1);
  localparam logic [IDX_W-1:0] STOP_IDX  = IDX_W'(`UART_FRAME_BITS - 1);

  logic             rx_meta;
  logic             rx_s;
  logic             rx_s_d;
  logic             busy;
  logic [CNT_W-1:0] baud_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             start_edge;
  logic             mid_bit;
  logic             frame_end;
  uart_byte_t       data_sh;
  logic             par_bit;
  logic             stop_bit;

  // two-flop sync plus one more for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_s_d  <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      rx_s_d  <= rx_s;
    end
  end

  assign start_edge = ~busy & rx_s_d & ~rx_s;
  assign mid_bit    = busy & (baud_cnt == HALF_LAST);
  assign frame_end  = busy & (bit_idx == STOP_IDX) & (baud_cnt == BAUD_LAST);
  assign rx_busy    = busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= frame_end;
      if (start_edge) begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end else if (busy) begin
        // start bit high again at mid-bit means a glitch
        if (mid_bit && bit_idx == '0 && rx_s) begin
          busy <= 1'b0;
        end else if (frame_end) begin
          busy <= 1'b0;
        end
        if (baud_cnt == BAUD_LAST) begin
          baud_cnt <= '0;
          bit_idx  <= bit_idx + 1'b1;
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mid_bit) begin
      if (bit_idx != '0 && bit_idx <= DATA_LAST) begin
        data_sh <= {rx_s, data_sh[7:1]};
      end else if (bit_idx == PAR_IDX) begin
        par_bit <= rx_s;
      end else if (bit_idx == STOP_IDX) begin
        stop_bit <= rx_s;
      end
    end
    if (frame_end) begin
      rx_byte <= data_sh;
      // odd parity means the xor over data and parity is one
      rx_bad  <= ~(^{data_sh, par_bit}) | ~stop_bit;
    end
  end

endmodule

//--- uart_tx/uart_tx.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module uart_tx import uart_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  uart_byte_t tx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       tx
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam int IDX_W = $clog2(`UART_FRAME_BITS);
  localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] BIT_LAST  = IDX_W'(`UART_FRAME_BITS - 1);

  logic                        busy;
  logic [`UART_FRAME_BITS-1:0] shreg;
  logic [CNT_W-1:0]            baud_cnt;
  logic [IDX_W-1:0]            bit_cnt;
  logic                        accept;

  assign tx_ready = ~busy;
  assign accept   = tx_valid & ~busy;

  // line follows bit 0 of the shifter, idle shifts in ones
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      shreg    <= '1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (accept) begin
      busy     <= 1'b1;
      // stop, odd parity, data lsb first, start
      shreg    <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (busy) begin
      if (baud_cnt == BAUD_LAST) begin
        baud_cnt <= '0;
        shreg    <= {1'b1, shreg[`UART_FRAME_BITS-1:1]};
        if (bit_cnt == BIT_LAST) begin
          // stop bit done
          busy    <= 1'b0;
          bit_cnt <= '0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

//--- common/uart_cmd_pkg.sv
package uart_cmd_pkg;

  typedef logic [7:0] uart_byte_t;

  typedef logic [6:0] reg_addr_t;

  // first frame is {rw, addr}, second is data
  typedef struct packed {
    logic       rw;
    reg_addr_t  addr;
    uart_byte_t data;
  } cmd_t;

  typedef struct packed {
    uart_byte_t data;
    logic       bad_frame;
    logic       timeout;
  } rd_resp_t;

  typedef enum logic [1:0] {
    IDLE,
    SEND_HI,
    SEND_LO,
    WAIT_RESP
  } ctrl_state_e;

endpackage

//--- common/uart_cmd_cfg.svh
`ifndef UART_CMD_CFG_SVH
`define UART_CMD_CFG_SVH

// clock cycles per serial bit, 4 or more
`define UART_CLKS_PER_BIT 16

// start + 8 data + parity + stop
`define UART_FRAME_BITS 11

// payload bits per frame
`define UART_DATA_BITS 8

// wait for reply start bit, 40 bit times
`define UART_RESP_TIMEOUT (40 * `UART_CLKS_PER_BIT)

`endif
